// ==== project.f ====
rtl/ooo_pkg.sv
rtl/dispatch_unit.sv
rtl/reg_status.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/exec_core_top.sv
verification/tb_exec_core.sv

// ==== Makefile ====
# Verilator build and run of the exec core testbench

SRCS := $(wildcard rtl/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_exec_core: $(SRCS) project.f
	verilator --binary --assert --top-module tb_exec_core -f project.f

run: obj_dir/Vtb_exec_core
	./obj_dir/Vtb_exec_core > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_exec_core.sv ====
////////////////////////////////////////
// tb_exec_core: table-driven testbench, in-order
// register model checks every broadcast by pc
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core;

    localparam int RS_SIZE = 8;
    localparam int TIMEOUT = 400;        // cycles allowed per wait

    // one table row, stimulus plus model result
    typedef struct packed {
        logic [31:0]              pc;
        logic [31:0]              inst;
        ooo_pkg::opa_select_t     opa_select;
        ooo_pkg::opb_select_t     opb_select;
        ooo_pkg::alu_func_t       alu_func;
        logic [ooo_pkg::XLEN-1:0] exp_value;
        ooo_pkg::areg_t           exp_dest;
    } stim_t;

    logic                      clock;
    logic                      reset;
    ooo_pkg::dispatch_packet_t dispatch;
    logic                      rs_full;
    ooo_pkg::cdb_t             result;

    stim_t       prog [$];                // whole run, program order
    int          idx_of_pc  [bit [31:0]];
    int          seen_of_pc [bit [31:0]]; // broadcasts per pc
    time         disp_time_of_pc [bit [31:0]];
    time         tag_free_at [2 ** ooo_pkg::TAG_LEN];  // last broadcast per tag
    logic [31:0] model_regs [32];         // reference arch regs
    logic [31:0] next_pc;
    logic [31:0] rnd;
    logic        saw_full;                // rs_full seen by the source
    int          error_count;
    int          check_count;
    int          err_base;
    int          test_num;
    int          tests_failed;

    exec_core_top #(.RS_SIZE(RS_SIZE)) u_exec_core_top (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .rs_full  (rs_full),
        .result   (result)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;      // 100 ns period
    end

    ////////////////////////////////////////
    // reference model and encoders
    ////////////////////////////////////////
    function automatic logic [31:0] model_alu(input ooo_pkg::alu_func_t func,
                                              input logic [31:0] a, input logic [31:0] b);
        int signed  sa;
        int signed  sb;
        logic [4:0] sh;
        sa = a;
        sb = b;
        sh = b[4:0];                     // shift amount from low bits
        case (func)
            ooo_pkg::ALU_ADD:  return a + b;
            ooo_pkg::ALU_SUB:  return a - b;
            ooo_pkg::ALU_AND:  return a & b;
            ooo_pkg::ALU_OR:   return a | b;
            ooo_pkg::ALU_XOR:  return a ^ b;
            ooo_pkg::ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            ooo_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ooo_pkg::ALU_SLL:  return a << sh;
            ooo_pkg::ALU_SRL:  return a >> sh;
            ooo_pkg::ALU_SRA:  return sa >>> sh;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [11:0] rand12();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    function automatic logic [31:0] enc_i(input int rd, input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), 3'b000, 5'(rd), 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(input int rd, input int rs1, input int rs2);
        return {7'h00, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_u(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'h37};
    endfunction

    // append a row, model runs in program order here
    task automatic add_op(input logic [31:0] inst, input ooo_pkg::opa_select_t opa_sel,
                          input ooo_pkg::opb_select_t opb_sel, input ooo_pkg::alu_func_t func);
        stim_t       s;
        logic [31:0] a;
        logic [31:0] b;
        case (opa_sel)
            ooo_pkg::OPA_IS_RS1: a = model_regs[inst[19:15]];
            ooo_pkg::OPA_IS_PC:  a = next_pc;
            ooo_pkg::OPA_IS_NPC: a = next_pc + 32'd4;
            default:             a = 32'd0;
        endcase
        case (opb_sel)
            ooo_pkg::OPB_IS_RS2:   b = model_regs[inst[24:20]];
            ooo_pkg::OPB_IS_I_IMM: b = {{20{inst[31]}}, inst[31:20]};
            ooo_pkg::OPB_IS_U_IMM: b = {inst[31:12], 12'h000};
            default:               b = 32'd0;
        endcase
        s.pc         = next_pc;
        s.inst       = inst;
        s.opa_select = opa_sel;
        s.opb_select = opb_sel;
        s.alu_func   = func;
        s.exp_value  = model_alu(func, a, b);
        s.exp_dest   = inst[11:7];
        if (inst[11:7] != 5'd0) begin
            model_regs[inst[11:7]] = s.exp_value;   // x0 stays zero
        end
        idx_of_pc[next_pc]       = prog.size();
        seen_of_pc[next_pc]      = 0;
        disp_time_of_pc[next_pc] = 0;            // not dispatched yet
        prog.push_back(s);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic op_imm(input ooo_pkg::alu_func_t func, input int rd, input int rs1,
                          input logic [11:0] imm);
        add_op(enc_i(rd, rs1, imm), ooo_pkg::OPA_IS_RS1, ooo_pkg::OPB_IS_I_IMM, func);
    endtask

    task automatic op_reg(input ooo_pkg::alu_func_t func, input int rd, input int rs1,
                          input int rs2);
        add_op(enc_r(rd, rs1, rs2), ooo_pkg::OPA_IS_RS1, ooo_pkg::OPB_IS_RS2, func);
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    // value and dest from the model, tag must be an entry freed before dispatch
    task automatic check_result(input ooo_pkg::cdb_t got,
                                input logic [ooo_pkg::XLEN-1:0] exp_value,
                                input ooo_pkg::areg_t exp_dest,
                                input time dispatched_at, input time tag_freed_at);
        check_count++;
        if ((got.value !== exp_value) || (got.dest_areg !== exp_dest)) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: pc %h gave x%0d = %h, expected x%0d = %h",
                     $time, got.pc, got.dest_areg, got.value, exp_dest, exp_value);
        end
        check_count++;
        if ((got.tag >= RS_SIZE) || (tag_freed_at >= dispatched_at)) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: pc %h used tag %0d, %s",
                     $time, got.pc, got.tag, "entry still pending at its dispatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - err_base;
        test_num++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (errs == 0) ? "pass" : "fail", errs);
        err_base = error_count;
    endtask

    // results sampled on the falling edge, matched by pc
    always @(negedge clock) begin : result_monitor
        int idx;
        if ((reset === 1'b0) && (result.valid === 1'b1)) begin
            if (!idx_of_pc.exists(result.pc)) begin
                error_count++;
                $display("broadcast carries unknown pc %h", result.pc);
            end else begin
                idx = idx_of_pc[result.pc];
                seen_of_pc[result.pc] = seen_of_pc[result.pc] + 1;
                if (seen_of_pc[result.pc] > 1) begin
                    error_count++;
                    $display("pc %h was broadcast more than once", result.pc);
                end
                check_result(result, prog[idx].exp_value, prog[idx].exp_dest,
                             disp_time_of_pc[result.pc], tag_free_at[result.tag]);
                tag_free_at[result.tag] = $time;
            end
        end
    end

    ////////////////////////////////////////
    // source and completion waits
    ////////////////////////////////////////
    task automatic apply_range(input int first, input int last);
        int waited;
        for (int i = first; i < last; i++) begin
            waited = 0;
            while ((rs_full !== 1'b0) && (waited < TIMEOUT)) begin
                saw_full       = 1'b1;
                dispatch.valid = 1'b0;       // hold off
                @(negedge clock);
                waited++;
            end
            if (rs_full !== 1'b0) begin
                error_count++;
                $display("rs_full stuck high, pc %h never dispatched", prog[i].pc);
            end else begin
                dispatch = '{valid: 1'b1, pc: prog[i].pc, inst: prog[i].inst,
                             opa_select: prog[i].opa_select,
                             opb_select: prog[i].opb_select,
                             alu_func: prog[i].alu_func};
                disp_time_of_pc[prog[i].pc] = $time;
                @(negedge clock);
            end
        end
        dispatch.valid = 1'b0;
    endtask

    task automatic wait_range(input int first, input int last);
        int cycles;
        for (int i = first; i < last; i++) begin
            cycles = 0;
            while ((seen_of_pc[prog[i].pc] == 0) && (cycles < TIMEOUT)) begin
                @(negedge clock);
                cycles++;
            end
            if (seen_of_pc[prog[i].pc] == 0) begin
                error_count++;
                $display("no result for pc %h within %0d cycles", prog[i].pc, TIMEOUT);
            end
        end
    endtask

    task automatic run_range(input int first);
        apply_range(first, prog.size());
        wait_range(first, prog.size());
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int first;
        void'($urandom(32'h4a07_a900));
        dispatch     = '0;
        reset        = 1'b1;
        next_pc      = 32'h0000_1000;
        saw_full     = 1'b0;
        error_count  = 0;
        check_count  = 0;
        err_base     = 0;
        test_num     = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < (2 ** ooo_pkg::TAG_LEN); i++) begin
            tag_free_at[i] = 0;
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        check_flag(rs_full, 1'b0, "rs_full after reset");
        check_flag(result.valid, 1'b0, "result.valid after reset");
        end_test("reset state");

        // one of each func, x0 plus random immediate
        first = prog.size();
        for (int k = 0; k < 10; k++) begin
            op_imm(ooo_pkg::alu_func_t'(k), 5 + k, 0, rand12());
        end
        run_range(first);
        end_test("independent alu ops");

        first = prog.size();
        rnd = $urandom();
        add_op(enc_i(15, 0, rnd[11:0]), ooo_pkg::OPA_IS_PC, ooo_pkg::OPB_IS_I_IMM, ooo_pkg::ALU_ADD);
        add_op(enc_i(16, 0, rnd[23:12]), ooo_pkg::OPA_IS_NPC, ooo_pkg::OPB_IS_I_IMM,
               ooo_pkg::ALU_ADD);
        add_op(enc_i(17, 0, 12'h000), ooo_pkg::OPA_IS_NPC, ooo_pkg::OPB_IS_I_IMM, ooo_pkg::ALU_ADD);
        rnd = $urandom();
        add_op(enc_u(18, rnd[19:0]), ooo_pkg::OPA_IS_ZERO, ooo_pkg::OPB_IS_U_IMM, ooo_pkg::ALU_ADD);
        add_op(enc_u(19, rnd[31:12]), ooo_pkg::OPA_IS_PC, ooo_pkg::OPB_IS_U_IMM, ooo_pkg::ALU_ADD);
        add_op(enc_i(20, 0, rand12()), ooo_pkg::OPA_IS_ZERO, ooo_pkg::OPB_IS_I_IMM, ooo_pkg::ALU_OR);
        add_op(enc_u(22, rnd[19:0]), ooo_pkg::OPA_IS_NPC, ooo_pkg::OPB_IS_U_IMM, ooo_pkg::ALU_SUB);
        run_range(first);
        end_test("operand selects");

        first = prog.size();
        op_imm(ooo_pkg::ALU_ADD, 1, 0, rand12());
        op_reg(ooo_pkg::ALU_ADD, 2, 1, 1);       // back-to-back reader
        op_reg(ooo_pkg::ALU_SUB, 3, 2, 1);
        op_imm(ooo_pkg::ALU_SLL, 4, 3, rand12());
        op_imm(ooo_pkg::ALU_ADD, 9, 0, rand12()); // competes for issue
        op_reg(ooo_pkg::ALU_SRA, 5, 4, 2);
        op_imm(ooo_pkg::ALU_SRL, 6, 5, rand12());
        op_reg(ooo_pkg::ALU_XOR, 7, 6, 3);
        op_reg(ooo_pkg::ALU_SLT, 8, 7, 1);
        op_reg(ooo_pkg::ALU_SLTU, 10, 7, 4);
        op_reg(ooo_pkg::ALU_AND, 1, 7, 9);       // rewrites x1
        op_reg(ooo_pkg::ALU_OR, 2, 1, 10);
        run_range(first);
        end_test("dependent chains");

        first = prog.size();
        op_imm(ooo_pkg::ALU_ADD, 13, 0, rand12());
        op_reg(ooo_pkg::ALU_ADD, 14, 13, 13);
        op_reg(ooo_pkg::ALU_ADD, 11, 14, 13);    // slow first writer
        op_imm(ooo_pkg::ALU_ADD, 11, 0, rand12()); // fast second writer
        op_reg(ooo_pkg::ALU_ADD, 12, 11, 0);
        op_imm(ooo_pkg::ALU_XOR, 0, 0, rand12());  // x0 target still broadcasts
        op_reg(ooo_pkg::ALU_OR, 16, 0, 0);
        run_range(first);
        end_test("write after write and x0");

        // long chain outruns the station
        first    = prog.size();
        saw_full = 1'b0;
        op_imm(ooo_pkg::ALU_ADD, 21, 0, rand12());
        for (int k = 1; k < 3 * RS_SIZE; k++) begin
            op_imm(ooo_pkg::ALU_ADD, 21, 21, rand12());
        end
        run_range(first);
        check_flag(saw_full, 1'b1, "rs_full during burst");
        end_test("burst with back-pressure");

        repeat (5) @(negedge clock);             // catch stray broadcasts
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/exec_core_top.sv ====
////////////////////////////////////////
// exec_core_top: dispatch, register status, one
// reservation station and the alu on a shared cdb
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module exec_core_top #(
    parameter int RS_SIZE = 8                     // 2 to 16 entries
) (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,   // strobe, held off by rs_full
    output logic                      rs_full,
    output ooo_pkg::cdb_t             result
);

    ooo_pkg::areg_t     rs1_areg;      // dispatch -> reg_status
    ooo_pkg::areg_t     rs2_areg;
    ooo_pkg::areg_t     dest_areg;
    ooo_pkg::operand_t  opa_status;    // reg_status -> dispatch
    ooo_pkg::operand_t  opb_status;
    ooo_pkg::rs_entry_t alloc_entry;   // dispatch -> rs
    ooo_pkg::tag_t      free_tag;      // rs -> reg_status
    ooo_pkg::rs_entry_t issue_entry;   // rs -> alu
    ooo_pkg::tag_t      issue_tag;
    logic               issue_valid;
    ooo_pkg::cdb_t      cdb;           // alu -> all

    assign result = cdb;

    dispatch_unit u_dispatch_unit (
        .dispatch    (dispatch),
        .opa_status  (opa_status),
        .opb_status  (opb_status),
        .cdb         (cdb),
        .rs1_areg    (rs1_areg),
        .rs2_areg    (rs2_areg),
        .dest_areg   (dest_areg),
        .alloc_entry (alloc_entry)
    );

    reg_status u_reg_status (
        .clock          (clock),
        .reset          (reset),
        .rs1_areg       (rs1_areg),
        .rs2_areg       (rs2_areg),
        .dest_areg      (dest_areg),
        .dispatch_valid (dispatch.valid),
        .free_tag       (free_tag),
        .cdb            (cdb),
        .opa_status     (opa_status),
        .opb_status     (opb_status)
    );

    reservation_station #(
        .RS_SIZE (RS_SIZE)
    ) u_reservation_station (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch.valid),
        .alloc_entry    (alloc_entry),
        .cdb            (cdb),
        .free_tag       (free_tag),
        .rs_full        (rs_full),
        .issue_entry    (issue_entry),
        .issue_tag      (issue_tag),
        .issue_valid    (issue_valid)
    );

    alu_unit u_alu_unit (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .issue_tag   (issue_tag),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
////////////////////////////////////////
// alu_unit: single-cycle integer op, registered cdb
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_valid,
    input  ooo_pkg::rs_entry_t issue_entry,
    input  ooo_pkg::tag_t      issue_tag,
    output ooo_pkg::cdb_t      cdb
);

    logic [ooo_pkg::XLEN-1:0] opa;
    logic [ooo_pkg::XLEN-1:0] opb;
    logic [4:0]               shamt;    // low bits of opb
    logic [ooo_pkg::XLEN-1:0] result;

    assign opa   = issue_entry.opa.value;
    assign opb   = issue_entry.opb.value;
    assign shamt = opb[4:0];

    always_comb begin
        case (issue_entry.alu_func)
            ooo_pkg::ALU_ADD:  result = opa + opb;
            ooo_pkg::ALU_SUB:  result = opa - opb;
            ooo_pkg::ALU_AND:  result = opa & opb;
            ooo_pkg::ALU_OR:   result = opa | opb;
            ooo_pkg::ALU_XOR:  result = opa ^ opb;
            ooo_pkg::ALU_SLT:  result = {31'b0, $signed(opa) < $signed(opb)};
            ooo_pkg::ALU_SLTU: result = {31'b0, opa < opb};
            ooo_pkg::ALU_SLL:  result = opa << shamt;
            ooo_pkg::ALU_SRL:  result = opa >> shamt;
            ooo_pkg::ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
            default:           result = '0;    // unused func codes
        endcase
    end

    // broadcast register, only valid is cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
        cdb.tag       <= issue_tag;
        cdb.dest_areg <= issue_entry.dest_areg;
        cdb.value     <= result;
        cdb.pc        <= issue_entry.pc;
    end

    // an entry never issues again while its own broadcast is on the bus
    a_no_reissue_in_flight : assert property (@(posedge clock) disable iff (reset)
        issue_valid && cdb.valid |-> (issue_tag != cdb.tag));

endmodule

`default_nettype wire

// ==== rtl/reservation_station.sv ====
////////////////////////////////////////
// reservation_station: holds dispatched ops, wakes
// operands on tag match, issues lowest ready entry
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module reservation_station #(
    parameter int RS_SIZE = 8
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  ooo_pkg::rs_entry_t alloc_entry,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::tag_t      free_tag,     // lowest free entry
    output logic               rs_full,
    output ooo_pkg::rs_entry_t issue_entry,
    output ooo_pkg::tag_t      issue_tag,
    output logic               issue_valid
);

    // tag space bounds the entry count
    if ((RS_SIZE < 2) || (RS_SIZE > (2 ** ooo_pkg::TAG_LEN))) begin : g_size_check
        $error("reservation_station: RS_SIZE out of range");
    end

    logic [RS_SIZE-1:0] occupied;      // allocated, result not yet broadcast
    logic [RS_SIZE-1:0] issued;        // sent to alu, waiting for own cdb
    logic [RS_SIZE-1:0] ready_vec;     // both operands ready, not issued
    logic [RS_SIZE-1:0] cdb_hit;       // entry named by current cdb
    ooo_pkg::rs_entry_t entries [RS_SIZE];

    ////////////////////////////////////////
    // status vectors and pickers
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready_vec[i] = occupied[i] && !issued[i] &&
                           entries[i].opa.ready && entries[i].opb.ready;
            cdb_hit[i]   = cdb.valid && (cdb.tag == ooo_pkg::tag_t'(i));
        end
    end

    assign rs_full     = &occupied;
    assign issue_valid = |ready_vec;

    // descending scan leaves the lowest index
    always_comb begin
        free_tag = '0;                 // don't care when full
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_tag = ooo_pkg::tag_t'(i);
            end
        end
    end

    always_comb begin
        issue_tag   = '0;
        issue_entry = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_tag   = ooo_pkg::tag_t'(i);
                issue_entry = entries[i];
            end
        end
    end

    ////////////////////////////////////////
    // entry control bits
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            occupied <= '0;
            issued   <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (cdb_hit[i]) begin              // own broadcast retires entry
                    occupied[i] <= 1'b0;
                    issued[i]   <= 1'b0;
                end
                if (issue_valid && (issue_tag == ooo_pkg::tag_t'(i))) begin
                    issued[i] <= 1'b1;
                end
                if (dispatch_valid && (free_tag == ooo_pkg::tag_t'(i))) begin
                    occupied[i] <= 1'b1;
                    issued[i]   <= 1'b0;
                end
            end
        end
    end

    // payload, wakeup on tag match
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (occupied[i] && cdb.valid) begin
                if (!entries[i].opa.ready && (entries[i].opa.tag == cdb.tag)) begin
                    entries[i].opa.ready <= 1'b1;
                    entries[i].opa.value <= cdb.value;
                end
                if (!entries[i].opb.ready && (entries[i].opb.tag == cdb.tag)) begin
                    entries[i].opb.ready <= 1'b1;
                    entries[i].opb.value <= cdb.value;
                end
            end
            if (dispatch_valid && (free_tag == ooo_pkg::tag_t'(i))) begin
                entries[i] <= alloc_entry;         // already bypassed upstream
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    a_no_dispatch_when_full : assert property (@(posedge clock) disable iff (reset)
        !(dispatch_valid && rs_full));

    // broadcast always belongs to a live, issued entry
    a_cdb_tag_live : assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> |(cdb_hit & occupied & issued));

endmodule

`default_nettype wire

// ==== rtl/reg_status.sv ====
////////////////////////////////////////
// reg_status: arch register values with busy bit and
// producer tag, updated by dispatch and the cdb
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module reg_status (
    input  logic              clock,
    input  logic              reset,
    input  ooo_pkg::areg_t    rs1_areg,
    input  ooo_pkg::areg_t    rs2_areg,
    input  ooo_pkg::areg_t    dest_areg,
    input  logic              dispatch_valid,
    input  ooo_pkg::tag_t     free_tag,      // tag given to the new producer
    input  ooo_pkg::cdb_t     cdb,
    output ooo_pkg::operand_t opa_status,
    output ooo_pkg::operand_t opb_status
);

    localparam int NUM_AREG = 2 ** ooo_pkg::AREG_LEN;

    logic [NUM_AREG-1:0]      busy;                // waiting on a station tag
    ooo_pkg::tag_t            tags   [NUM_AREG];   // producer of pending value
    logic [ooo_pkg::XLEN-1:0] values [NUM_AREG];
    logic [NUM_AREG-1:0]      tag_live;            // busy and naming free_tag

    // x0 hardwired, always ready and zero
    function automatic ooo_pkg::operand_t read_reg(input ooo_pkg::areg_t idx);
        ooo_pkg::operand_t res;
        res.ready = !busy[idx];
        res.tag   = tags[idx];
        res.value = values[idx];
        if (idx == '0) begin
            res = '{ready: 1'b1, tag: '0, value: '0};
        end
        return res;
    endfunction

    assign opa_status = read_reg(rs1_areg);
    assign opb_status = read_reg(rs2_areg);

    ////////////////////////////////////////
    // update
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < NUM_AREG; i++) begin
                tags[i]   <= '0;
                values[i] <= '0;
            end
        end else begin
            // writeback only if this broadcast is still the latest producer
            if (cdb.valid && busy[cdb.dest_areg] && (tags[cdb.dest_areg] == cdb.tag)) begin
                busy[cdb.dest_areg]   <= 1'b0;
                values[cdb.dest_areg] <= cdb.value;
            end
            // new producer overrides a same-edge writeback
            if (dispatch_valid && (dest_areg != '0)) begin
                busy[dest_areg] <= 1'b1;
                tags[dest_areg] <= free_tag;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_AREG; i++) begin
            tag_live[i] = busy[i] && (tags[i] == free_tag);
        end
    end

    // a new producer never takes a tag some register still waits on
    a_free_tag_not_pending : assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !(|tag_live));

endmodule

`default_nettype wire

// ==== rtl/dispatch_unit.sv ====
////////////////////////////////////////
// dispatch_unit: field decode, immediates and
// operand muxing into a new station entry
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dispatch_unit (
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  ooo_pkg::operand_t         opa_status,   // status of rs1
    input  ooo_pkg::operand_t         opb_status,   // status of rs2
    input  ooo_pkg::cdb_t             cdb,          // same-cycle bypass
    output ooo_pkg::areg_t            rs1_areg,
    output ooo_pkg::areg_t            rs2_areg,
    output ooo_pkg::areg_t            dest_areg,
    output ooo_pkg::rs_entry_t        alloc_entry
);

    logic [ooo_pkg::XLEN-1:0] i_imm;
    logic [ooo_pkg::XLEN-1:0] u_imm;
    logic [ooo_pkg::XLEN-1:0] npc;
    ooo_pkg::operand_t        opa_reg;   // rs1 after bypass
    ooo_pkg::operand_t        opb_reg;   // rs2 after bypass

    // a waiting operand picks up a broadcast of its producer
    function automatic ooo_pkg::operand_t bypass(input ooo_pkg::operand_t op,
                                                 input ooo_pkg::cdb_t bus);
        ooo_pkg::operand_t res;
        res = op;
        if (!op.ready && bus.valid && (bus.tag == op.tag)) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign rs1_areg  = dispatch.inst[19:15];
    assign rs2_areg  = dispatch.inst[24:20];
    assign dest_areg = dispatch.inst[11:7];

    assign i_imm = {{20{dispatch.inst[31]}}, dispatch.inst[31:20]};  // sign-extended
    assign u_imm = {dispatch.inst[31:12], 12'h000};
    assign npc   = dispatch.pc + 32'd4;

    assign opa_reg = bypass(opa_status, cdb);
    assign opb_reg = bypass(opb_status, cdb);

    ////////////////////////////////////////
    // operand muxes
    ////////////////////////////////////////
    always_comb begin
        alloc_entry.opa = '{ready: 1'b1, tag: '0, value: '0};  // non-reg default
        case (dispatch.opa_select)
            ooo_pkg::OPA_IS_RS1:  alloc_entry.opa = opa_reg;
            ooo_pkg::OPA_IS_PC:   alloc_entry.opa.value = dispatch.pc;
            ooo_pkg::OPA_IS_NPC:  alloc_entry.opa.value = npc;
            ooo_pkg::OPA_IS_ZERO: alloc_entry.opa.value = '0;
            default:              alloc_entry.opa.value = '0;
        endcase

        alloc_entry.opb = '{ready: 1'b1, tag: '0, value: '0};
        case (dispatch.opb_select)
            ooo_pkg::OPB_IS_RS2:   alloc_entry.opb = opb_reg;
            ooo_pkg::OPB_IS_I_IMM: alloc_entry.opb.value = i_imm;
            ooo_pkg::OPB_IS_U_IMM: alloc_entry.opb.value = u_imm;
            default:               alloc_entry.opb.value = '0;   // unused code
        endcase

        alloc_entry.alu_func  = dispatch.alu_func;
        alloc_entry.dest_areg = dest_areg;
        alloc_entry.pc        = dispatch.pc;
    end

endmodule

`default_nettype wire

// ==== rtl/ooo_pkg.sv ====
////////////////////////////////////////
// ooo_pkg: widths, select/func enums and the packed
// structs shared by the dispatch, station and alu blocks
////////////////////////////////////////
`default_nettype none

package ooo_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    parameter int XLEN     = 32;   // data width
    parameter int AREG_LEN = 5;    // 32 architectural regs
    parameter int TAG_LEN  = 4;    // up to 16 station entries

    typedef logic [AREG_LEN-1:0] areg_t;   // arch register index
    typedef logic [TAG_LEN-1:0]  tag_t;    // station entry index

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_NPC  = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_select_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2   = 2'h0,
        OPB_IS_I_IMM = 2'h1,
        OPB_IS_U_IMM = 2'h2   // 2'h3 unused
    } opb_select_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    // decoded instruction from the front end
    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        logic [31:0]      inst;         // raw RV32 word
        opa_select_t      opa_select;
        opb_select_t      opb_select;
        alu_func_t        alu_func;
    } dispatch_packet_t;

    // one source operand, value or producer tag
    typedef struct packed {
        logic             ready;
        tag_t             tag;          // valid while !ready
        logic [XLEN-1:0]  value;
    } operand_t;

    // station payload
    typedef struct packed {
        operand_t         opa;
        operand_t         opb;
        alu_func_t        alu_func;
        areg_t            dest_areg;
        logic [XLEN-1:0]  pc;
    } rs_entry_t;

    // result broadcast
    typedef struct packed {
        logic             valid;
        tag_t             tag;          // producing station entry
        areg_t            dest_areg;
        logic [XLEN-1:0]  value;
        logic [XLEN-1:0]  pc;
    } cdb_t;

endpackage

`default_nettype wire
